// File: hw/texcache_pkg.sv
/*
 * Texture cache definitions.
 * Cache geometry, address types and the refill FSM states.
 */
package texcache_pkg;

	localparam int FML_DEPTH   = 26; // memory byte address width.
	localparam int CACHE_DEPTH = 13; // 8 KiB of cache.
	localparam int LINE_BITS   = 5;  // a line is one 4x64-bit burst.
	localparam int INDEX_W     = CACHE_DEPTH - LINE_BITS;
	localparam int TAG_W       = FML_DEPTH - CACHE_DEPTH;
	localparam int NUM_LINES   = 2 ** INDEX_W;
	localparam int DADR_W      = CACHE_DEPTH - 2; // 32-bit word index inside the cache.
	localparam int NUM_TEX     = 4; // texels A, B, C and D.

	// a byte address splits into tag, line index and offset, from the top down.
	typedef logic [FML_DEPTH-2:0] tadr_t; // counts 16-bit words.
	typedef logic [FML_DEPTH-1:0] badr_t;
	typedef logic [5:0] frac_t;

	typedef enum logic [2:0] {
		IDLE,
		DATA1,
		DATA2,
		DATA3,
		DATA4,
		WAIT,
		FLUSH
	} refill_state_e;

endpackage

// File: hw/texcache_wr_if.sv
/*
 * Cache write bus.
 * Carries tag and data memory writes from the refill engine to the lookup stage.
 */
interface texcache_wr_if import texcache_pkg::*; ();

	logic               tag_we;
	logic [INDEX_W-1:0] tag_aw;
	logic               tag_valid;
	logic [TAG_W-1:0]   tag_dw;
	logic               data_we;
	logic [INDEX_W+1:0] data_aw; // line index followed by the beat number.

	modport refill (
		output tag_we, tag_aw, tag_valid, tag_dw,
		output data_we, data_aw
	);

	modport lookup (
		input tag_we, tag_aw, tag_valid, tag_dw,
		input data_we, data_aw
	);

endinterface

// File: hw/texcache_tagmem.sv
/*
 * Tag memory.
 * One valid bit and one tag per line, four synchronous reads and one write.
 */
module texcache_tagmem import texcache_pkg::*; (
	input  logic                            sys_clk,
	input  logic                            sys_rst,
	input  logic [NUM_TEX-1:0][INDEX_W-1:0] rd_idx_i,
	output logic [NUM_TEX-1:0]              rd_valid_o,
	output logic [NUM_TEX-1:0][TAG_W-1:0]   rd_tag_o,
	texcache_wr_if.lookup                   wr
);

	logic [NUM_LINES-1:0] valid;
	logic [TAG_W-1:0] tags [NUM_LINES];

	// the cache comes out of reset empty.
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			valid <= '0;
		else if (wr.tag_we)
			valid[wr.tag_aw] <= wr.tag_valid;
	end

	always_ff @(posedge sys_clk) begin
		if (wr.tag_we)
			tags[wr.tag_aw] <= wr.tag_dw;
	end

	// reads return the old contents when they hit the line being written.
	always_ff @(posedge sys_clk) begin
		for (int k = 0; k < NUM_TEX; k++) begin
			rd_valid_o[k] <= valid[rd_idx_i[k]];
			rd_tag_o[k] <= tags[rd_idx_i[k]];
		end
	end

endmodule

// File: hw/texcache_datamem.sv
/*
 * Data memory.
 * Written one 64-bit beat at a time, read as four 32-bit ports.
 */
module texcache_datamem import texcache_pkg::*; (
	input  logic                           sys_clk,
	input  logic [NUM_TEX-1:0][DADR_W-1:0] rd_adr_i,
	output logic [NUM_TEX-1:0][31:0]       rd_data_o,
	texcache_wr_if.lookup                  wr,
	input  logic [63:0]                    fml_di_i
);

	logic [63:0] mem [2**(INDEX_W+2)];

	always_ff @(posedge sys_clk) begin
		if (wr.data_we)
			mem[wr.data_aw] <= fml_di_i;
	end

	// memory is big-endian, so the lower word address sits in the upper half.
	always_ff @(posedge sys_clk) begin
		for (int k = 0; k < NUM_TEX; k++) begin
			if (rd_adr_i[k][0])
				rd_data_o[k] <= mem[rd_adr_i[k][DADR_W-1:1]][31:0];
			else
				rd_data_o[k] <= mem[rd_adr_i[k][DADR_W-1:1]][63:32];
		end
	end

endmodule

// File: hw/texcache_lookup.sv
/*
 * Texture cache lookup stage.
 * Holds one item, checks its four texels against the tags and
 * either passes the colors on or asks the refill engine for a line.
 */
module texcache_lookup import texcache_pkg::*; (
	input  logic          sys_clk,
	input  logic          sys_rst,
	input  logic          pipe_stb_i,
	output logic          pipe_ack_o,
	input  tadr_t         dadr_i,
	input  tadr_t         tadra_i,
	input  tadr_t         tadrb_i,
	input  tadr_t         tadrc_i,
	input  tadr_t         tadrd_i,
	input  frac_t         x_frac_i,
	input  frac_t         y_frac_i,
	output logic          pipe_stb_o,
	input  logic          pipe_ack_i,
	output tadr_t         dadr_o,
	output logic [15:0]   tcolora_o,
	output logic [15:0]   tcolorb_o,
	output logic [15:0]   tcolorc_o,
	output logic [15:0]   tcolord_o,
	output frac_t         x_frac_o,
	output frac_t         y_frac_o,
	input  logic [63:0]   fml_di_i,
	output logic          fetch_req_o,
	output badr_t         fetch_adr_o,
	texcache_wr_if.lookup wr
);

	badr_t [NUM_TEX-1:0] tadr_in; // byte addresses at the input.
	badr_t [NUM_TEX-1:0] tadr_q;  // byte addresses of the held item.
	badr_t [NUM_TEX-1:0] rd_adr;
	logic [NUM_TEX-1:0][INDEX_W-1:0] tag_idx;
	logic [NUM_TEX-1:0][DADR_W-1:0] data_adr;
	logic [NUM_TEX-1:0] valid_rd;
	logic [NUM_TEX-1:0][TAG_W-1:0] tag_rd;
	logic [NUM_TEX-1:0][31:0] data_rd;
	logic [NUM_TEX-1:0][15:0] color;
	logic [NUM_TEX-1:0] need;
	logic [NUM_TEX-1:0] hit;
	logic item_vld;
	logic tag_we_r;

	assign tadr_in = {{tadrd_i, 1'b0}, {tadrc_i, 1'b0}, {tadrb_i, 1'b0}, {tadra_i, 1'b0}};

	// a slot is free when empty or when its item leaves this cycle.
	assign pipe_ack_o = ~item_vld | (pipe_stb_o & pipe_ack_i);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			item_vld <= 1'b0;
			tag_we_r <= 1'b0;
		end else begin
			if (pipe_ack_o)
				item_vld <= pipe_stb_i;
			tag_we_r <= wr.tag_we; // memory reads lag a tag write by one cycle.
		end
	end

	always_ff @(posedge sys_clk) begin
		if (pipe_stb_i & pipe_ack_o) begin
			tadr_q <= tadr_in;
			dadr_o <= dadr_i;
			x_frac_o <= x_frac_i;
			y_frac_o <= y_frac_i;
		end
	end

	// a held item keeps reading its own addresses until it leaves.
	always_comb begin
		for (int k = 0; k < NUM_TEX; k++) begin
			rd_adr[k] = pipe_ack_o ? tadr_in[k] : tadr_q[k];
			tag_idx[k] = rd_adr[k][CACHE_DEPTH-1:LINE_BITS];
			data_adr[k] = rd_adr[k][CACHE_DEPTH-1:2];
		end
	end

	texcache_tagmem u_tagmem (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.rd_idx_i   (tag_idx),
		.rd_valid_o (valid_rd),
		.rd_tag_o   (tag_rd),
		.wr         (wr)
	);

	texcache_datamem u_datamem (
		.sys_clk   (sys_clk),
		.rd_adr_i  (data_adr),
		.rd_data_o (data_rd),
		.wr        (wr),
		.fml_di_i  (fml_di_i)
	);

	// with an integer coordinate the neighbouring texel has zero weight.
	assign need[0] = 1'b1;
	assign need[1] = x_frac_o != '0;
	assign need[2] = y_frac_o != '0;
	assign need[3] = (x_frac_o != '0) | (y_frac_o != '0);

	always_comb begin
		for (int k = 0; k < NUM_TEX; k++) begin
			hit[k] = ~need[k] |
				(valid_rd[k] & (tag_rd[k] == tadr_q[k][FML_DEPTH-1:CACHE_DEPTH]));
			color[k] = tadr_q[k][1] ? data_rd[k][15:0] : data_rd[k][31:16];
		end
	end

	assign pipe_stb_o = item_vld & ~tag_we_r & (&hit);
	assign fetch_req_o = item_vld & ~tag_we_r & ~(&hit);

	// first missing texel wins, in the order A, B, C, D.
	always_comb begin
		fetch_adr_o = tadr_q[NUM_TEX-1];
		for (int k = NUM_TEX - 1; k >= 0; k--) begin
			if (~hit[k])
				fetch_adr_o = tadr_q[k];
		end
	end

	assign tcolora_o = color[0];
	assign tcolorb_o = color[1];
	assign tcolorc_o = color[2];
	assign tcolord_o = color[3];

endmodule

// File: hw/texcache_refill.sv
/*
 * Texture cache refill engine.
 * Fetches a missing line as a four-beat burst and writes its tag last,
 * or walks all lines to invalidate them on a flush.
 */
module texcache_refill import texcache_pkg::*; (
	input  logic          sys_clk,
	input  logic          sys_rst,
	input  logic          fetch_req_i,
	input  badr_t         fetch_adr_i,
	input  logic          flush_i,
	output logic          busy_o,
	output badr_t         fml_adr_o,
	output logic          fml_stb_o,
	input  logic          fml_ack_i,
	texcache_wr_if.refill wr
);

	refill_state_e state;
	refill_state_e next_state;
	badr_t adr_q;
	logic [1:0] beat;
	logic [INDEX_W-1:0] line_cnt;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_ff @(posedge sys_clk) begin
		if (state == IDLE && fml_stb_o)
			adr_q <= fetch_adr_i; // held for the whole burst and the tag write.
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst || state == IDLE)
			beat <= 2'd0;
		else if (wr.data_we)
			beat <= beat + 2'd1;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst || state != FLUSH)
			line_cnt <= '0;
		else
			line_cnt <= line_cnt + 1'b1;
	end

	// the request goes out in IDLE, before the address has been captured.
	assign fml_adr_o = (state == IDLE) ? fetch_adr_i : adr_q;
	assign busy_o = state != IDLE;

	assign wr.tag_aw = (state == FLUSH) ? line_cnt : adr_q[CACHE_DEPTH-1:LINE_BITS];
	assign wr.tag_dw = adr_q[FML_DEPTH-1:CACHE_DEPTH];
	assign wr.data_aw = {adr_q[CACHE_DEPTH-1:LINE_BITS], beat};

	always_comb begin
		next_state = state;
		fml_stb_o = 1'b0;
		wr.data_we = 1'b0;
		wr.tag_we = 1'b0;
		wr.tag_valid = 1'b1;
		case (state)
			IDLE: begin
				if (flush_i) begin
					next_state = FLUSH;
				end else if (fetch_req_i) begin
					fml_stb_o = 1'b1;
					next_state = DATA1;
				end
			end
			DATA1: begin
				fml_stb_o = 1'b1;
				if (fml_ack_i) begin
					wr.data_we = 1'b1; // beat 0 arrives with the ack.
					next_state = DATA2;
				end
			end
			DATA2: begin
				wr.data_we = 1'b1;
				next_state = DATA3;
			end
			DATA3: begin
				wr.data_we = 1'b1;
				next_state = DATA4;
			end
			DATA4: begin
				wr.data_we = 1'b1;
				wr.tag_we = 1'b1; // the line only becomes visible once all of it is in.
				next_state = WAIT;
			end
			WAIT: next_state = IDLE; // lets fetch_req see the new tag.
			FLUSH: begin
				wr.tag_we = 1'b1;
				wr.tag_valid = 1'b0;
				if (&line_cnt)
					next_state = IDLE;
			end
			default: next_state = IDLE;
		endcase
	end

endmodule

// File: hw/texcache_top.sv
/*
 * Texture cache.
 * Four-texel lookup per cycle with a burst refill engine behind it.
 */
module texcache_top import texcache_pkg::*; (
	input  logic        sys_clk,
	input  logic        sys_rst,
	output badr_t       fml_adr_o,
	output logic        fml_stb_o,
	input  logic        fml_ack_i,
	input  logic [63:0] fml_di_i,
	input  logic        flush_i,
	output logic        busy_o,
	input  logic        pipe_stb_i,
	output logic        pipe_ack_o,
	input  tadr_t       dadr_i,
	input  tadr_t       tadra_i,
	input  tadr_t       tadrb_i,
	input  tadr_t       tadrc_i,
	input  tadr_t       tadrd_i,
	input  frac_t       x_frac_i,
	input  frac_t       y_frac_i,
	output logic        pipe_stb_o,
	input  logic        pipe_ack_i,
	output tadr_t       dadr_o,
	output logic [15:0] tcolora_o,
	output logic [15:0] tcolorb_o,
	output logic [15:0] tcolorc_o,
	output logic [15:0] tcolord_o,
	output frac_t       x_frac_o,
	output frac_t       y_frac_o
);

	logic fetch_req;
	badr_t fetch_adr;

	texcache_wr_if wr_bus ();

	texcache_lookup u_lookup (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.pipe_stb_i  (pipe_stb_i),
		.pipe_ack_o  (pipe_ack_o),
		.dadr_i      (dadr_i),
		.tadra_i     (tadra_i),
		.tadrb_i     (tadrb_i),
		.tadrc_i     (tadrc_i),
		.tadrd_i     (tadrd_i),
		.x_frac_i    (x_frac_i),
		.y_frac_i    (y_frac_i),
		.pipe_stb_o  (pipe_stb_o),
		.pipe_ack_i  (pipe_ack_i),
		.dadr_o      (dadr_o),
		.tcolora_o   (tcolora_o),
		.tcolorb_o   (tcolorb_o),
		.tcolorc_o   (tcolorc_o),
		.tcolord_o   (tcolord_o),
		.x_frac_o    (x_frac_o),
		.y_frac_o    (y_frac_o),
		.fml_di_i    (fml_di_i),
		.fetch_req_o (fetch_req),
		.fetch_adr_o (fetch_adr),
		.wr          (wr_bus)
	);

	texcache_refill u_refill (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.fetch_req_i (fetch_req),
		.fetch_adr_i (fetch_adr),
		.flush_i     (flush_i),
		.busy_o      (busy_o),
		.fml_adr_o   (fml_adr_o),
		.fml_stb_o   (fml_stb_o),
		.fml_ack_i   (fml_ack_i),
		.wr          (wr_bus)
	);

endmodule

// File: tb/tb_clkgen.sv
/*
 * Testbench clock and reset.
 * 4 ns clock, reset held high for the first eight cycles.
 */
module tb_clkgen (
	output logic sys_clk_o,
	output logic sys_rst_o
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		sys_clk_o = 1'b0;
		forever #2 sys_clk_o = ~sys_clk_o;
	end

	initial begin
		sys_rst_o = 1'b1;
		repeat (8) @(posedge sys_clk_o);
		sys_rst_o <= 1'b0; // released on an edge like any other input.
	end

endmodule

// File: tb/tb_texcache.sv
/*
 * Texture cache testbench.
 * Replays the stimulus vectors against a burst memory model and checks
 * colors, forwarded fields, burst addresses and burst counts.
 */
module tb_texcache import texcache_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WAIT_LIMIT = 400;

	logic sys_clk;
	logic sys_rst;
	badr_t fml_adr;
	logic fml_stb;
	logic fml_ack;
	logic [63:0] fml_di;
	logic flush;
	logic busy;
	logic pipe_stb_in;
	logic pipe_ack_out;
	tadr_t dadr;
	tadr_t [NUM_TEX-1:0] tadr_in;
	frac_t x_frac;
	frac_t y_frac;
	logic pipe_stb_out;
	logic pipe_ack_in;
	tadr_t dadr_out;
	logic [15:0] tcolor_a;
	logic [15:0] tcolor_b;
	logic [15:0] tcolor_c;
	logic [15:0] tcolor_d;
	logic [NUM_TEX-1:0][15:0] tcolor;
	frac_t x_frac_out;
	frac_t y_frac_out;

	int seed = 32'h1de06454;
	int burst_cnt = 0;
	badr_t exp_bursts [$]; // line addresses the cache model expects to be fetched.
	logic line_vld [NUM_LINES];
	logic [TAG_W-1:0] line_tag [NUM_LINES];
	tadr_t item_dadr;
	tadr_t item_tadr [NUM_TEX];
	frac_t item_xf;
	frac_t item_yf;

	assign tcolor = {tcolor_d, tcolor_c, tcolor_b, tcolor_a};

	tb_clkgen u_clkgen (.sys_clk_o(sys_clk), .sys_rst_o(sys_rst));

	texcache_top UUT (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.fml_adr_o  (fml_adr),
		.fml_stb_o  (fml_stb),
		.fml_ack_i  (fml_ack),
		.fml_di_i   (fml_di),
		.flush_i    (flush),
		.busy_o     (busy),
		.pipe_stb_i (pipe_stb_in),
		.pipe_ack_o (pipe_ack_out),
		.dadr_i     (dadr),
		.tadra_i    (tadr_in[0]),
		.tadrb_i    (tadr_in[1]),
		.tadrc_i    (tadr_in[2]),
		.tadrd_i    (tadr_in[3]),
		.x_frac_i   (x_frac),
		.y_frac_i   (y_frac),
		.pipe_stb_o (pipe_stb_out),
		.pipe_ack_i (pipe_ack_in),
		.dadr_o     (dadr_out),
		.tcolora_o  (tcolor_a),
		.tcolorb_o  (tcolor_b),
		.tcolorc_o  (tcolor_c),
		.tcolord_o  (tcolor_d),
		.x_frac_o   (x_frac_out),
		.y_frac_o   (y_frac_out)
	);

	task automatic end_with_failure();
		$display("Test failures found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_timeout(input string what);
		$display("TIMEOUT: %s", what);
		end_with_failure();
	endtask

	task automatic compare_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
			end_with_failure();
		end
	endtask

	// every 16-bit word of memory is its whole word address folded and scrambled.
	function automatic logic [15:0] mem_word(input tadr_t w);
		return w[15:0] ^ {7'd0, w[FML_DEPTH-2:16]} ^ 16'h5a5a;
	endfunction

	function automatic logic [63:0] beat_data(input badr_t adr);
		tadr_t w;
		w = adr[FML_DEPTH-1:1];
		return {mem_word(w), mem_word(w + 1), mem_word(w + 2), mem_word(w + 3)};
	endfunction

	// B needs a horizontal fraction, C a vertical one, D either of them.
	function automatic logic texel_needed(input int k);
		case (k)
			1: return item_xf != 0;
			2: return item_yf != 0;
			3: return (item_xf != 0) || (item_yf != 0);
			default: return 1'b1;
		endcase
	endfunction

	// direct-mapped cache model; each retry fetches the first missing texel.
	task automatic predict_bursts();
		badr_t b;
		logic [INDEX_W-1:0] idx;
		logic missed;
		for (int n = 0; n < NUM_TEX; n++) begin
			missed = 1'b0;
			for (int k = 0; k < NUM_TEX && !missed; k++) begin
				b = {item_tadr[k], 1'b0};
				idx = b[CACHE_DEPTH-1:LINE_BITS];
				if (texel_needed(k) &&
						!(line_vld[idx] && line_tag[idx] == b[FML_DEPTH-1:CACHE_DEPTH])) begin
					exp_bursts.push_back(b);
					line_vld[idx] = 1'b1;
					line_tag[idx] = b[FML_DEPTH-1:CACHE_DEPTH];
					missed = 1'b1;
				end
			end
		end
	endtask

	task automatic check_outputs();
		compare_value("pipe_stb_o", pipe_stb_out, 1);
		compare_value("dadr_o", dadr_out, item_dadr);
		compare_value("x_frac_o", x_frac_out, item_xf);
		compare_value("y_frac_o", y_frac_out, item_yf);
		for (int k = 0; k < NUM_TEX; k++) begin
			if (texel_needed(k))
				compare_value($sformatf("tcolor%c_o", "a" + k), tcolor[k],
					mem_word(item_tadr[k]));
		end
	endtask

	task automatic flush_cache();
		int n;
		for (n = 0; n <= WAIT_LIMIT; n++) begin
			@(posedge sys_clk);
			if (!busy)
				break;
		end
		if (n > WAIT_LIMIT)
			report_timeout("busy_o stayed high before the flush");
		flush <= 1'b1;
		@(posedge sys_clk);
		flush <= 1'b0;
		@(posedge sys_clk);
		compare_value("busy_o", busy, 1); // the flush has started.
		for (n = 0; n <= 2 * NUM_LINES; n++) begin
			@(posedge sys_clk);
			if (!busy)
				break;
		end
		if (n > 2 * NUM_LINES)
			report_timeout("the flush never finished");
		for (int i = 0; i < NUM_LINES; i++)
			line_vld[i] = 1'b0;
	endtask

	// memory model with a random ack delay; beat 0 comes with the ack.
	initial begin : memory_model
		badr_t base;
		badr_t exp_adr;
		int delay;
		forever begin
			@(posedge sys_clk);
			if (fml_stb) begin
				burst_cnt++;
				if (exp_bursts.size() == 0) begin
					$display("ERROR: burst at 0x%0h while no miss was expected", fml_adr);
					end_with_failure();
				end else begin
					exp_adr = exp_bursts.pop_front();
					compare_value("fml_adr_o", fml_adr[FML_DEPTH-1:LINE_BITS],
						exp_adr[FML_DEPTH-1:LINE_BITS]);
				end
				base = {fml_adr[FML_DEPTH-1:LINE_BITS], {LINE_BITS{1'b0}}};
				delay = $unsigned($random(seed)) % 4;
				repeat (delay) @(posedge sys_clk);
				for (int i = 0; i < 4; i++) begin
					fml_ack <= (i == 0);
					fml_di <= beat_data(base + 8 * i);
					@(posedge sys_clk);
				end
			end
		end
	end

	initial begin : stimulus
		int fd;
		int n;
		int cnt_start;
		int hold;
		int exp_cnt;
		string line;
		logic do_flush;

		fml_ack <= 1'b0;
		fml_di <= '0;
		flush <= 1'b0;
		pipe_stb_in <= 1'b0;
		pipe_ack_in <= 1'b1;
		dadr <= '0;
		tadr_in <= '0;
		x_frac <= '0;
		y_frac <= '0;
		for (int i = 0; i < NUM_LINES; i++)
			line_vld[i] = 1'b0;
		fd = $fopen("tb/texcache_stimulus.txt", "r");
		if (fd == 0) begin
			$display("ERROR: the stimulus file could not be opened");
			end_with_failure();
		end
		for (n = 0; n <= WAIT_LIMIT; n++) begin
			@(posedge sys_clk);
			if (!sys_rst)
				break;
		end
		if (n > WAIT_LIMIT)
			report_timeout("reset was never released");
		compare_value("pipe_ack_o", pipe_ack_out, 1);
		compare_value("pipe_stb_o", pipe_stb_out, 0);
		compare_value("busy_o", busy, 0);
		compare_value("fml_stb_o", fml_stb, 0);

		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", do_flush, item_dadr,
				item_tadr[0], item_tadr[1], item_tadr[2], item_tadr[3],
				item_xf, item_yf, hold, exp_cnt);
			if (n != 10) begin
				$display("ERROR: malformed stimulus line: %s", line);
				end_with_failure();
			end
			if (do_flush)
				flush_cache();
			cnt_start = burst_cnt;
			predict_bursts();
			@(posedge sys_clk);
			pipe_stb_in <= 1'b1;
			dadr <= item_dadr;
			tadr_in <= {item_tadr[3], item_tadr[2], item_tadr[1], item_tadr[0]};
			x_frac <= item_xf;
			y_frac <= item_yf;
			pipe_ack_in <= (hold == 0); // a held item stays at the output.
			for (n = 0; n <= WAIT_LIMIT; n++) begin
				@(posedge sys_clk);
				if (pipe_ack_out)
					break;
			end
			if (n > WAIT_LIMIT)
				report_timeout("the cache never accepted the item");
			pipe_stb_in <= 1'b0;
			for (n = 0; n <= WAIT_LIMIT; n++) begin
				@(posedge sys_clk);
				if (pipe_stb_out)
					break;
			end
			if (n > WAIT_LIMIT)
				report_timeout("the cache never produced the item");
			check_outputs();
			for (int i = 0; i < hold; i++) begin
				@(posedge sys_clk);
				compare_value("pipe_ack_o", pipe_ack_out, 0);
				check_outputs();
			end
			pipe_ack_in <= 1'b1;
			compare_value("fml_stb_o bursts", burst_cnt - cnt_start, exp_cnt);
		end
		$fclose(fd);
		$display("All tests passed!");
		$finish;
	end

endmodule

// File: tb/texcache_stimulus.txt
# flush dadr tadra tadrb tadrc tadrd x_frac y_frac hold bursts, all in hex.
# pixel and texel addresses count 16-bit words; hold is cycles with pipe_ack_i low.
0 0000100 0010000 0010001 0010040 0010041 10 20 0 2
0 0000101 0010002 0010003 0010042 0010043 08 08 0 0
0 0000102 0010004 0020000 0010044 0010045 00 15 0 0
0 0000103 0010005 0010006 0030100 0010046 21 00 0 0
0 0000104 0010007 0040000 0050000 0060000 00 00 0 0
0 1abcdef 0010008 001000a 0010048 001004a 3f 3f 5 0
1 0000105 0010000 0010001 0010040 0010041 10 20 0 2
0 0000106 0010002 0070123 0010042 0080456 01 01 0 2
0 0000107 0100200 0100210 0100220 0100230 02 03 3 4
0 0000108 0110200 0110201 0110202 0110203 04 04 0 1
0 0000109 0100205 0100215 0100225 0100235 01 01 0 1
1 000010a 0020010 0030000 0040000 0050000 00 00 0 1
0 000010b 0020011 0030000 0040000 0050000 00 00 2 0
0 000010c 0020012 0020013 0020014 0020015 3f 01 0 0

// File: sources.f
hw/texcache_pkg.sv
hw/texcache_wr_if.sv
hw/texcache_tagmem.sv
hw/texcache_datamem.sv
hw/texcache_lookup.sv
hw/texcache_refill.sv
hw/texcache_top.sv
tb/tb_clkgen.sv
tb/tb_texcache.sv
